// File: design/refill_defs.svh
`ifndef REFILL_DEFS_SVH
`define REFILL_DEFS_SVH

// byte address and bus word
`define ADDR_W     32
`define WORD_W     32

// cache line geometry
`define LINE_WORDS 8
`define LINE_W     256
`define OFFSET_W   5

// AR field widths
`define LEN_W      8
`define SIZE_W     3

// one fixed id per requester so two bursts can overlap
`define ID_W       4
`define INST_ID    0
`define DATA_ID    1

`endif

// File: design/refill_pkg.sv
`include "refill_defs.svh"

package refill_pkg;

    // requester FSM
    typedef enum logic [1:0] {
        REFILL_IDLE = 2'd0,
        REFILL_ADDR = 2'd1,
        REFILL_DATA = 2'd2,
        REFILL_RET  = 2'd3
    } refill_state_e;

    // data side opcode
    typedef enum logic {
        RD_WORD = 1'b0,
        RD_LINE = 1'b1
    } rd_type_e;

endpackage

// File: design/inst_refill_port.sv
`timescale 1ns/1ps
`include "refill_defs.svh"

module inst_refill_port import refill_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                rd_req,
    input  logic [`ADDR_W-1:0]  rd_addr,
    output logic                rd_rdy,
    output logic                ar_valid,
    output logic [`ADDR_W-1:0]  ar_addr,
    output logic [`LEN_W-1:0]   ar_len,
    output logic [`SIZE_W-1:0]  ar_size,
    input  logic                ar_ready,
    input  logic                r_valid,
    input  logic [`WORD_W-1:0]  r_data,
    input  logic                r_last,
    output logic                r_ready,
    output logic                ret_valid,
    output logic [`LINE_W-1:0]  ret_data
);

    refill_state_e                state;
    logic [`ADDR_W-1:0]           line_addr;
    logic [`LINE_W-1:0]           line_buf;
    logic [$clog2(`LINE_WORDS):0] beat_cnt;
    logic                         req_fire;
    logic                         beat_fire;

    assign req_fire  = rd_req && rd_rdy;
    assign beat_fire = r_valid && r_ready;

    assign rd_rdy    = (state == REFILL_IDLE);
    assign ar_valid  = (state == REFILL_ADDR);
    assign r_ready   = (state == REFILL_DATA);
    assign ret_valid = (state == REFILL_RET);

    // always a full line of 4-byte beats
    assign ar_addr  = line_addr;
    assign ar_len   = `LEN_W'(`LINE_WORDS - 1);
    assign ar_size  = `SIZE_W'($clog2(`WORD_W / 8));
    assign ret_data = line_buf;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= REFILL_IDLE;
        end else begin
            case (state)
                REFILL_IDLE: begin
                    if (req_fire) begin
                        state <= REFILL_ADDR;
                    end
                end
                REFILL_ADDR: begin
                    if (ar_ready) begin
                        state <= REFILL_DATA;
                    end
                end
                REFILL_DATA: begin
                    if (beat_fire && r_last) begin
                        state <= REFILL_RET;
                    end
                end
                REFILL_RET: begin
                    state <= REFILL_IDLE;
                end
                default: begin
                    state <= REFILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (req_fire) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_fire) begin
            line_addr <= {rd_addr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
        end
    end

    // shift in from the top so word 0 ends up lowest
    always_ff @(posedge aclk) begin
        if (beat_fire) begin
            line_buf <= {r_data, line_buf[`LINE_W-1:`WORD_W]};
        end
    end

    a_no_beat_past_line: assert property (
        @(posedge aclk) disable iff (!rst_n)
        beat_fire |-> (beat_cnt < `LINE_WORDS)
    );

endmodule

// File: design/data_refill_port.sv
`timescale 1ns/1ps
`include "refill_defs.svh"

module data_refill_port import refill_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                rd_req,
    input  rd_type_e            rd_type,
    input  logic [`ADDR_W-1:0]  rd_addr,
    input  logic [`SIZE_W-1:0]  rd_size,
    output logic                rd_rdy,
    output logic                ar_valid,
    output logic [`ADDR_W-1:0]  ar_addr,
    output logic [`LEN_W-1:0]   ar_len,
    output logic [`SIZE_W-1:0]  ar_size,
    input  logic                ar_ready,
    input  logic                r_valid,
    input  logic [`WORD_W-1:0]  r_data,
    input  logic                r_last,
    output logic                r_ready,
    output logic                ret_valid,
    output logic [`LINE_W-1:0]  ret_data
);

    refill_state_e        state;
    rd_type_e             req_type;
    logic [`ADDR_W-1:0]   req_addr;
    logic [`SIZE_W-1:0]   req_size;
    logic [`LINE_W-1:0]   line_buf;
    logic                 req_fire;
    logic                 beat_fire;
    logic                 line_mode;

    assign req_fire  = rd_req && rd_rdy;
    assign beat_fire = r_valid && r_ready;
    assign line_mode = (req_type == RD_LINE);

    assign rd_rdy    = (state == REFILL_IDLE);
    assign ar_valid  = (state == REFILL_ADDR);
    assign r_ready   = (state == REFILL_DATA);
    assign ret_valid = (state == REFILL_RET);

    // uncached word reads go out as a single beat of the requested size
    assign ar_addr  = req_addr;
    assign ar_len   = line_mode ? `LEN_W'(`LINE_WORDS - 1) : '0;
    assign ar_size  = line_mode ? `SIZE_W'($clog2(`WORD_W / 8)) : req_size;
    assign ret_data = line_buf;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= REFILL_IDLE;
        end else begin
            case (state)
                REFILL_IDLE: begin
                    if (req_fire) begin
                        state <= REFILL_ADDR;
                    end
                end
                REFILL_ADDR: begin
                    if (ar_ready) begin
                        state <= REFILL_DATA;
                    end
                end
                REFILL_DATA: begin
                    if (beat_fire && r_last) begin
                        state <= REFILL_RET;
                    end
                end
                REFILL_RET: begin
                    state <= REFILL_IDLE;
                end
                default: begin
                    state <= REFILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            req_type <= RD_LINE;
        end else if (req_fire) begin
            req_type <= rd_type;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_fire) begin
            req_size <= rd_size;
            if (rd_type == RD_LINE) begin
                req_addr <= {rd_addr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
            end else begin
                req_addr <= rd_addr;
            end
        end
    end

    // line beats shift down while a single word lands in the low slot
    always_ff @(posedge aclk) begin
        if (beat_fire) begin
            if (line_mode) begin
                line_buf <= {r_data, line_buf[`LINE_W-1:`WORD_W]};
            end else begin
                line_buf <= {{(`LINE_W - `WORD_W){1'b0}}, r_data};
            end
        end
    end

    a_word_single_beat: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (beat_fire && !line_mode) |-> r_last
    );

endmodule

// File: design/axi_read_arbiter.sv
`timescale 1ns/1ps
`include "refill_defs.svh"

module axi_read_arbiter (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                inst_ar_valid,
    input  logic [`ADDR_W-1:0]  inst_ar_addr,
    input  logic [`LEN_W-1:0]   inst_ar_len,
    input  logic [`SIZE_W-1:0]  inst_ar_size,
    output logic                inst_ar_ready,
    input  logic                data_ar_valid,
    input  logic [`ADDR_W-1:0]  data_ar_addr,
    input  logic [`LEN_W-1:0]   data_ar_len,
    input  logic [`SIZE_W-1:0]  data_ar_size,
    output logic                data_ar_ready,
    input  logic                inst_r_ready,
    input  logic                data_r_ready,
    output logic                inst_r_valid,
    output logic                data_r_valid,
    output logic [`WORD_W-1:0]  r_data,
    output logic                r_last,
    output logic [`ID_W-1:0]    arid,
    output logic [`ADDR_W-1:0]  araddr,
    output logic [`LEN_W-1:0]   arlen,
    output logic [`SIZE_W-1:0]  arsize,
    output logic                arvalid,
    input  logic                arready,
    input  logic [`ID_W-1:0]    rid,
    input  logic [`WORD_W-1:0]  rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);

    logic lock;
    logic lock_data;
    logic sel_data;
    logic rid_inst;
    logic rid_data;

    // a stalled AR keeps its owner, otherwise data goes first
    assign sel_data = lock ? lock_data : data_ar_valid;

    assign arvalid = sel_data ? data_ar_valid : inst_ar_valid;
    assign araddr  = sel_data ? data_ar_addr  : inst_ar_addr;
    assign arlen   = sel_data ? data_ar_len   : inst_ar_len;
    assign arsize  = sel_data ? data_ar_size  : inst_ar_size;
    assign arid    = sel_data ? `ID_W'(`DATA_ID) : `ID_W'(`INST_ID);

    assign inst_ar_ready = arready && !sel_data;
    assign data_ar_ready = arready && sel_data;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            lock      <= 1'b0;
            lock_data <= 1'b0;
        end else begin
            lock      <= arvalid && !arready;
            lock_data <= sel_data;
        end
    end

    // R beats steered back by id
    assign rid_inst = (rid == `ID_W'(`INST_ID));
    assign rid_data = (rid == `ID_W'(`DATA_ID));

    assign inst_r_valid = rvalid && rid_inst;
    assign data_r_valid = rvalid && rid_data;
    assign rready       = (rid_inst && inst_r_ready) || (rid_data && data_r_ready);
    assign r_data       = rdata;
    assign r_last       = rlast;

    a_ar_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (arvalid && !arready) |=> ($stable(araddr) && $stable(arid))
    );

endmodule

// File: design/refill_top.sv
`timescale 1ns/1ps
`include "refill_defs.svh"

module refill_top import refill_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                inst_rd_req,
    input  logic [`ADDR_W-1:0]  inst_rd_addr,
    output logic                inst_rd_rdy,
    output logic                inst_ret_valid,
    output logic [`LINE_W-1:0]  inst_ret_data,
    input  logic                data_rd_req,
    input  rd_type_e            data_rd_type,
    input  logic [`ADDR_W-1:0]  data_rd_addr,
    input  logic [`SIZE_W-1:0]  data_rd_size,
    output logic                data_rd_rdy,
    output logic                data_ret_valid,
    output logic [`LINE_W-1:0]  data_ret_data,
    output logic [`ID_W-1:0]    arid,
    output logic [`ADDR_W-1:0]  araddr,
    output logic [`LEN_W-1:0]   arlen,
    output logic [`SIZE_W-1:0]  arsize,
    output logic                arvalid,
    input  logic                arready,
    input  logic [`ID_W-1:0]    rid,
    input  logic [`WORD_W-1:0]  rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);

    logic                inst_ar_valid;
    logic [`ADDR_W-1:0]  inst_ar_addr;
    logic [`LEN_W-1:0]   inst_ar_len;
    logic [`SIZE_W-1:0]  inst_ar_size;
    logic                inst_ar_ready;
    logic                inst_r_valid;
    logic                inst_r_ready;
    logic                data_ar_valid;
    logic [`ADDR_W-1:0]  data_ar_addr;
    logic [`LEN_W-1:0]   data_ar_len;
    logic [`SIZE_W-1:0]  data_ar_size;
    logic                data_ar_ready;
    logic                data_r_valid;
    logic                data_r_ready;
    logic [`WORD_W-1:0]  r_data;
    logic                r_last;

    inst_refill_port u_inst_port (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rd_req    (inst_rd_req),
        .rd_addr   (inst_rd_addr),
        .rd_rdy    (inst_rd_rdy),
        .ar_valid  (inst_ar_valid),
        .ar_addr   (inst_ar_addr),
        .ar_len    (inst_ar_len),
        .ar_size   (inst_ar_size),
        .ar_ready  (inst_ar_ready),
        .r_valid   (inst_r_valid),
        .r_data    (r_data),
        .r_last    (r_last),
        .r_ready   (inst_r_ready),
        .ret_valid (inst_ret_valid),
        .ret_data  (inst_ret_data)
    );

    data_refill_port u_data_port (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rd_req    (data_rd_req),
        .rd_type   (data_rd_type),
        .rd_addr   (data_rd_addr),
        .rd_size   (data_rd_size),
        .rd_rdy    (data_rd_rdy),
        .ar_valid  (data_ar_valid),
        .ar_addr   (data_ar_addr),
        .ar_len    (data_ar_len),
        .ar_size   (data_ar_size),
        .ar_ready  (data_ar_ready),
        .r_valid   (data_r_valid),
        .r_data    (r_data),
        .r_last    (r_last),
        .r_ready   (data_r_ready),
        .ret_valid (data_ret_valid),
        .ret_data  (data_ret_data)
    );

    axi_read_arbiter u_arbiter (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .inst_ar_valid (inst_ar_valid),
        .inst_ar_addr  (inst_ar_addr),
        .inst_ar_len   (inst_ar_len),
        .inst_ar_size  (inst_ar_size),
        .inst_ar_ready (inst_ar_ready),
        .data_ar_valid (data_ar_valid),
        .data_ar_addr  (data_ar_addr),
        .data_ar_len   (data_ar_len),
        .data_ar_size  (data_ar_size),
        .data_ar_ready (data_ar_ready),
        .inst_r_ready  (inst_r_ready),
        .data_r_ready  (data_r_ready),
        .inst_r_valid  (inst_r_valid),
        .data_r_valid  (data_r_valid),
        .r_data        (r_data),
        .r_last        (r_last),
        .arid          (arid),
        .araddr        (araddr),
        .arlen         (arlen),
        .arsize        (arsize),
        .arvalid       (arvalid),
        .arready       (arready),
        .rid           (rid),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rready        (rready)
    );

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps
`include "refill_defs.svh"

module axi_mem_model (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic [`ID_W-1:0]    arid,
    input  logic [`ADDR_W-1:0]  araddr,
    input  logic [`LEN_W-1:0]   arlen,
    input  logic                arvalid,
    output logic                arready,
    output logic [`ID_W-1:0]    rid,
    output logic [`WORD_W-1:0]  rdata,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready
);

    logic [31:0]        lfsr;
    logic               rst_q;
    logic               ar_hs;
    logic               r_hs;
    logic               busy;
    logic [`ID_W-1:0]   ar_id_q;
    logic [`ADDR_W-1:0] ar_addr_q;
    logic [`LEN_W-1:0]  ar_len_q;
    logic [`ADDR_W-1:0] base;
    logic [`LEN_W-1:0]  last_beat;
    logic [`LEN_W-1:0]  beat;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // handshakes and reset seen on the rising edge and acted on at the falling edge
    always @(posedge aclk) begin
        rst_q     <= rst_n;
        ar_hs     <= arvalid && arready;
        r_hs      <= rvalid && rready;
        ar_id_q   <= arid;
        ar_addr_q <= araddr;
        ar_len_q  <= arlen;
    end

    always @(negedge aclk) begin
        if (!rst_q) begin
            lfsr      = 32'd81056;
            busy      = 1'b0;
            base      = '0;
            last_beat = '0;
            beat      = '0;
            arready   = 1'b0;
            rvalid    = 1'b0;
            rlast     = 1'b0;
            rid       = '0;
            rdata     = '0;
        end else begin
            if (ar_hs) begin
                busy      = 1'b1;
                base      = {ar_addr_q[`ADDR_W-1:2], 2'b00};
                last_beat = ar_len_q;
                rid       = ar_id_q;
                beat      = '0;
            end
            if (r_hs) begin
                if (beat == last_beat) begin
                    busy = 1'b0;
                end else begin
                    beat = beat + 1'b1;
                end
            end
            // an offered beat stays up until taken
            if (!busy) begin
                rvalid = 1'b0;
            end else if (!rvalid || r_hs) begin
                lfsr   = lfsr_step(lfsr);
                rvalid = lfsr[0];
            end
            // beats step by one word
            rdata   = ~(base + {beat, 2'b00});
            rlast   = (beat == last_beat);
            lfsr    = lfsr_step(lfsr);
            arready = !busy && lfsr[0];
        end
    end

endmodule

// File: dv/refill_tb.sv
`timescale 1ns/1ps
`include "refill_defs.svh"

module refill_tb import refill_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = 400;
    // data requests read a region of their own
    localparam logic [`ADDR_W-1:0] DATA_OFS = 32'h400;

    logic                aclk;
    logic                rst_n;
    logic                inst_rd_req;
    logic [`ADDR_W-1:0]  inst_rd_addr;
    logic                inst_rd_rdy;
    logic                inst_ret_valid;
    logic [`LINE_W-1:0]  inst_ret_data;
    logic                data_rd_req;
    rd_type_e            data_rd_type;
    logic [`ADDR_W-1:0]  data_rd_addr;
    logic [`SIZE_W-1:0]  data_rd_size;
    logic                data_rd_rdy;
    logic                data_ret_valid;
    logic [`LINE_W-1:0]  data_ret_data;
    logic [`ID_W-1:0]    arid;
    logic [`ADDR_W-1:0]  araddr;
    logic [`LEN_W-1:0]   arlen;
    logic [`SIZE_W-1:0]  arsize;
    logic                arvalid;
    logic                arready;
    logic [`ID_W-1:0]    rid;
    logic [`WORD_W-1:0]  rdata;
    logic                rlast;
    logic                rvalid;
    logic                rready;

    // expected arlen and arsize belong to the data request when there is one
    logic                t_inst  [NUM_TESTS];
    logic                t_data  [NUM_TESTS];
    rd_type_e            t_type  [NUM_TESTS];
    logic [`ADDR_W-1:0]  t_addr  [NUM_TESTS];
    logic [`SIZE_W-1:0]  t_size  [NUM_TESTS];
    logic [`LEN_W-1:0]   t_len   [NUM_TESTS];
    logic [`SIZE_W-1:0]  t_esize [NUM_TESTS];

    int   errors;
    int   fails;
    int   tests_run;
    logic timed_out;

    refill_top u_refill_top (.*);

    axi_mem_model u_mem (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #5 aclk = ~aclk;
        end
    end

    task automatic set_row(input int i, input logic inst, input logic data, input rd_type_e typ,
                           input logic [`ADDR_W-1:0] addr, input logic [`SIZE_W-1:0] size,
                           input logic [`LEN_W-1:0] len, input logic [`SIZE_W-1:0] esize);
        t_inst[i]  = inst;
        t_data[i]  = data;
        t_type[i]  = typ;
        t_addr[i]  = addr;
        t_size[i]  = size;
        t_len[i]   = len;
        t_esize[i] = esize;
    endtask

    task automatic check_value(input string what, input logic [`LINE_W-1:0] got,
                               input logic [`LINE_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // word i of a line is the inverse of its byte address
    function automatic logic [`LINE_W-1:0] expected_ret(input logic [`ADDR_W-1:0] addr,
                                                        input logic line);
        logic [`LINE_W-1:0] v;
        logic [`ADDR_W-1:0] base;
        v    = '0;
        base = addr & 32'hffff_ffe0;
        if (line) begin
            for (int i = 0; i < `LINE_WORDS; i++) begin
                v[i*`WORD_W +: `WORD_W] = ~(base + `ADDR_W'(4 * i));
            end
        end else begin
            v[`WORD_W-1:0] = ~(addr & 32'hffff_fffc);
        end
        return v;
    endfunction

    function automatic logic [`ADDR_W-1:0] ar_target(input logic [`ADDR_W-1:0] addr,
                                                     input logic line);
        return line ? (addr & 32'hffff_ffe0) : addr;
    endfunction

    task automatic run_entry(input int t);
        logic [`ADDR_W-1:0] d_addr;
        logic [`ADDR_W-1:0] held_addr;
        logic [`ID_W-1:0]   held_id;
        logic               inst_done;
        logic               data_done;
        logic               stalled;
        int                 cyc;
        int                 ar_seen;
        int                 inst_ars;
        int                 data_ars;
        int                 errs_before;
        errs_before = errors;
        d_addr      = t_addr[t] + DATA_OFS;
        cyc         = 0;
        @(negedge aclk);
        while (!(inst_rd_rdy && data_rd_rdy) && cyc < TIMEOUT) begin
            @(negedge aclk);
            cyc++;
        end
        if (!(inst_rd_rdy && data_rd_rdy)) begin
            $display("timeout: ports never went idle before test %0d", t);
            timed_out = 1'b1;
        end else begin
            inst_rd_req  = t_inst[t];
            inst_rd_addr = t_addr[t];
            data_rd_req  = t_data[t];
            data_rd_type = t_type[t];
            data_rd_addr = d_addr;
            data_rd_size = t_size[t];
            @(posedge aclk);
            @(negedge aclk);
            inst_rd_req = 1'b0;
            data_rd_req = 1'b0;
            inst_done = !t_inst[t];
            data_done = !t_data[t];
            stalled   = 1'b0;
            ar_seen   = 0;
            inst_ars  = 0;
            data_ars  = 0;
            cyc       = 0;
            while (!(inst_done && data_done) && cyc < TIMEOUT) begin
                @(posedge aclk);
                cyc++;
                if (stalled) begin
                    check_value("araddr during AR stall", araddr, held_addr);
                    check_value("arid during AR stall", arid, held_id);
                end
                stalled   = arvalid && !arready;
                held_addr = araddr;
                held_id   = arid;
                if (arvalid && arready) begin
                    if (ar_seen == 0) begin
                        check_value("first arid", arid, t_data[t] ? `DATA_ID : `INST_ID);
                    end
                    ar_seen++;
                    if (arid == `ID_W'(`DATA_ID)) begin
                        data_ars++;
                        check_value("data araddr", araddr, ar_target(d_addr, t_type[t] == RD_LINE));
                        check_value("data arlen", arlen, t_len[t]);
                        check_value("data arsize", arsize, t_esize[t]);
                    end else begin
                        inst_ars++;
                        check_value("inst arid", arid, `INST_ID);
                        check_value("inst araddr", araddr, ar_target(t_addr[t], 1'b1));
                        check_value("inst arlen", arlen, t_data[t] ? 7 : t_len[t]);
                        check_value("inst arsize", arsize, t_data[t] ? 2 : t_esize[t]);
                    end
                end
                if (inst_ret_valid) begin
                    check_value("inst ret_valid expected", !inst_done, 1'b1);
                    check_value("inst ret_data", inst_ret_data, expected_ret(t_addr[t], 1'b1));
                    inst_done = 1'b1;
                end else if (!inst_done) begin
                    check_value("inst rd_rdy while busy", inst_rd_rdy, 1'b0);
                end
                if (data_ret_valid) begin
                    check_value("data ret_valid expected", !data_done, 1'b1);
                    check_value("data ret_data", data_ret_data,
                                expected_ret(d_addr, t_type[t] == RD_LINE));
                    data_done = 1'b1;
                end else if (!data_done) begin
                    check_value("data rd_rdy while busy", data_rd_rdy, 1'b0);
                end
            end
            if (!(inst_done && data_done)) begin
                $display("timeout: test %0d got no return within %0d cycles", t, TIMEOUT);
                timed_out = 1'b1;
            end else begin
                check_value("inst AR count", inst_ars, t_inst[t]);
                check_value("data AR count", data_ars, t_data[t]);
            end
        end
        tests_run++;
        if (timed_out || errors != errs_before) begin
            fails++;
        end
        $display("test %0d: %s", t, (timed_out || errors != errs_before) ? "FAILED" : "ok");
    endtask

    initial begin
        int t;
        errors       = 0;
        fails        = 0;
        tests_run    = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        inst_rd_req  = 1'b0;
        inst_rd_addr = '0;
        data_rd_req  = 1'b0;
        data_rd_type = RD_LINE;
        data_rd_addr = '0;
        data_rd_size = '0;
        //      inst  data  type     addr          size  len  esize
        set_row(0, 1'b1, 1'b0, RD_LINE, 32'h0000_1234, 3'd2, 8'd7, 3'd2);
        set_row(1, 1'b0, 1'b1, RD_LINE, 32'h0001_2a5c, 3'd2, 8'd7, 3'd2);
        set_row(2, 1'b0, 1'b1, RD_WORD, 32'h0002_3007, 3'd0, 8'd0, 3'd0);
        set_row(3, 1'b0, 1'b1, RD_WORD, 32'h8000_0106, 3'd1, 8'd0, 3'd1);
        set_row(4, 1'b1, 1'b1, RD_LINE, 32'h0004_5018, 3'd2, 8'd7, 3'd2);
        set_row(5, 1'b1, 1'b1, RD_WORD, 32'h0005_6c04, 3'd2, 8'd0, 3'd2);
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);
        t = errors;
        check_value("arvalid after reset", arvalid, 1'b0);
        check_value("rready after reset", rready, 1'b0);
        check_value("inst ret_valid after reset", inst_ret_valid, 1'b0);
        check_value("data ret_valid after reset", data_ret_valid, 1'b0);
        check_value("inst rd_rdy after reset", inst_rd_rdy, 1'b1);
        check_value("data rd_rdy after reset", data_rd_rdy, 1'b1);
        tests_run++;
        if (errors != t) begin
            fails++;
        end
        $display("test reset: %s", (errors != t) ? "FAILED" : "ok");
        for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_entry(t);
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - fails, fails, errors);
        if (fails == 0 && errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+design
design/refill_pkg.sv
design/inst_refill_port.sv
design/data_refill_port.sv
design/axi_read_arbiter.sv
design/refill_top.sv
dv/axi_mem_model.sv
dv/refill_tb.sv

// File: Bender.yml
package:
  name: axi_refill

sources:
  - include_dirs:
      - design
    files:
      - design/refill_pkg.sv
      - design/inst_refill_port.sv
      - design/data_refill_port.sv
      - design/axi_read_arbiter.sv
      - design/refill_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/axi_mem_model.sv
      - dv/refill_tb.sv
